// ==== rtl/dma_params.svh ====
// ======================================================================
// Widths and depths shared by the DMA receive engine and its testbench
// Include wherever a width or depth is needed
// ======================================================================
`ifndef DMA_PARAMS_SVH
`define DMA_PARAMS_SVH

// Data path
`define DMA_DATA_W     32   // Bus and buffer word width
`define DMA_LEN_W      16   // Packet length field, bytes

// Queues
`define DMA_NUM_Q      4    // Packet queues in the buffer
`define DMA_Q_W        2    // Queue index width

// Counters and storage
`define DMA_WCNT_W     14   // Word counter width
`define DMA_FIFO_DEPTH 4    // Read FIFO entries

`endif

// ==== rtl/dma_pkg.sv ====
// ======================================================================
// Types of the DMA receive engine: controller states and data widths
// ======================================================================
`default_nettype none

`include "dma_params.svh"

package dma_pkg;

   // Controller states
   typedef enum logic [2:0] {
      IDLE,     // Wait for buffer ownership
      ARB,      // Wait for a queue with a packet
      REQ,      // Request the packet from the buffer
      GET_LEN,  // Read the length word
      MOVE,     // Stream packet words into the FIFO
      FINISH,   // Wait for the last bus write
      RELEASE   // Wait for the host to take the buffer back
   } dma_state_e;

   typedef logic [`DMA_DATA_W-1:0]   word_t;   // One data word
   typedef logic [`DMA_Q_W-1:0]      queue_t;  // Queue index
   typedef logic [`DMA_LEN_W-1:0]    len_t;    // Byte length
   typedef logic [`DMA_WCNT_W-1:0]   wcnt_t;   // Word count
   typedef logic [`DMA_DATA_W/8-1:0] sel_t;    // Byte selects

endpackage

`default_nettype wire

// ==== rtl/dma_fifo_if.sv ====
// ======================================================================
// Word path from the buffer reader through the read FIFO to the bus master
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

interface dma_fifo_if;
   import dma_pkg::*;

   logic  push;         // Write one word
   word_t push_data;
   logic  pop;          // Drop the head word
   word_t pop_data;     // Head word
   logic  empty;
   logic  nearly_full;  // Three or more words held

   // Buffer reader side
   modport writer (output push, output push_data, input nearly_full);

   // Storage
   modport fifo (input push, input push_data, input pop,
                 output pop_data, output empty, output nearly_full);

   // Bus master side
   modport reader (output pop, input pop_data, input empty);

endinterface

`default_nettype wire

// ==== rtl/dma_xfer_if.sv ====
// ======================================================================
// Per-packet handoff from the controller to the bus master
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

interface dma_xfer_if;
   import dma_pkg::*;

   logic  start;     // One-cycle pulse, words and last_sel valid with it
   wcnt_t words;     // Packet word count minus one
   sel_t  last_sel;  // Selects of the last word, little-endian lanes
   logic  done;      // One-cycle pulse after the last ack

   modport ctrl   (output start, output words, output last_sel, input done);

   modport master (input start, input words, input last_sel, output done);

endinterface

`default_nettype wire

// ==== rtl/dma_rr_arb.sv ====
// ======================================================================
// Round-robin pick of the next packet queue, starting after the last grant
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "dma_params.svh"

module dma_rr_arb (
   input  wire                      clk,
   input  wire                      arst_n,
   input  wire [`DMA_NUM_Q-1:0]     pkt_avail,  // One bit per queue
   input  wire                      take,       // Accept current grant
   output logic                     grant_vld,
   output dma_pkg::queue_t          grant_q
);
   import dma_pkg::*;

   queue_t last_q;  // Last granted queue

   // Search upward from last_q + 1, wrapping
   // Walk from the far end so the nearest hit wins
   always_comb
   begin
      queue_t idx;
      grant_vld = 1'b0;
      grant_q   = last_q;
      for (int i = `DMA_NUM_Q; i >= 1; i--)
      begin
         idx = queue_t'(int'(last_q) + i);   // Wraps with the index width
         if (pkt_avail[idx])
         begin
            grant_vld = 1'b1;
            grant_q   = idx;
         end
      end
   end

   // Pointer moves only when the controller takes the grant
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         last_q <= queue_t'(`DMA_NUM_Q - 1);  // First search starts at queue 0
      end
      else if (take)
      begin
         last_q <= grant_q;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dma_ctrl.sv ====
// ======================================================================
// Receive controller: ownership, queue request, length word and buffer reads
// Starts the bus master per packet and reports queue and size to the host
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "dma_params.svh"

module dma_ctrl (
   input  wire              clk,
   input  wire              arst_n,
   input  wire              rd_owner,   // Engine owns the host buffer
   input  dma_pkg::word_t   rd_addr,    // Host buffer byte address
   input  wire              grant_vld,
   input  dma_pkg::queue_t  grant_q,
   output logic             take,
   output logic             buf_req,
   output dma_pkg::queue_t  buf_req_q,
   output logic             buf_rd_en,
   input  dma_pkg::word_t   buf_data,   // Valid the cycle after buf_rd_en
   output dma_pkg::queue_t  rd_mac,
   output dma_pkg::len_t    rd_size,
   output logic             rd_done,
   output logic             addr_err,
   dma_fifo_if.writer       fifo,
   dma_xfer_if.ctrl         xfer
);
   import dma_pkg::*;

   dma_state_e state, state_nxt;
   queue_t     q_sel;     // Queue being served
   wcnt_t      rd_cnt;    // Buffer reads left minus one
   logic       len_vld;   // Length word on buf_data
   logic       dat_vld;   // Packet word on buf_data
   len_t       len_w;
   logic       misalign;

   assign len_w    = buf_data[`DMA_LEN_W-1:0];
   assign misalign = (rd_addr[1:0] != 2'b00);

   // ==================================================================
   // Outputs toward arbiter, buffer and master
   // ==================================================================
   assign take      = (state == ARB) && grant_vld;
   assign buf_req   = (state == REQ);
   assign buf_req_q = q_sel;

   always_comb
   begin
      case (state)
         GET_LEN: buf_rd_en = !len_vld;          // Single length read
         MOVE:    buf_rd_en = !fifo.nearly_full; // Back-pressure from FIFO
         default: buf_rd_en = 1'b0;
      endcase
   end

   assign fifo.push      = dat_vld;
   assign fifo.push_data = buf_data;

   // Master start with the length word
   assign xfer.start = (state == GET_LEN) && len_vld;
   assign xfer.words = wcnt_t'((len_w - 1'b1) >> 2);  // Last word index

   always_comb
   begin
      case (len_w[1:0])
         2'd1:    xfer.last_sel = 4'b0001;
         2'd2:    xfer.last_sel = 4'b0011;
         2'd3:    xfer.last_sel = 4'b0111;
         default: xfer.last_sel = 4'b1111;  // Whole last word
      endcase
   end

   // ==================================================================
   // State machine
   // ==================================================================
   always_comb
   begin
      state_nxt = state;
      case (state)
         IDLE:    if (rd_owner) state_nxt = misalign ? RELEASE : ARB;
         ARB:     if (grant_vld) state_nxt = REQ;
         REQ:     state_nxt = GET_LEN;
         GET_LEN: if (len_vld) state_nxt = MOVE;
         MOVE:    if (buf_rd_en && rd_cnt == '0) state_nxt = FINISH;
         FINISH:  if (xfer.done) state_nxt = RELEASE;
         RELEASE: if (!rd_owner) state_nxt = IDLE;
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         state    <= IDLE;
         rd_cnt   <= '0;
         len_vld  <= 1'b0;
         dat_vld  <= 1'b0;
         rd_done  <= 1'b0;
         addr_err <= 1'b0;
      end
      else
      begin
         state    <= state_nxt;
         len_vld  <= (state == GET_LEN) && buf_rd_en;
         dat_vld  <= (state == MOVE) && buf_rd_en;
         rd_done  <= (state == FINISH) && xfer.done;
         addr_err <= (state == IDLE) && rd_owner && misalign;
         if (xfer.start)
            rd_cnt <= xfer.words;
         else if (state == MOVE && buf_rd_en && rd_cnt != '0)
            rd_cnt <= rd_cnt - 1'b1;
      end
   end

   // Queue and size, held for the host
   always_ff @(posedge clk)
   begin
      if (take)
         q_sel <= grant_q;
      if (xfer.start)
      begin
         rd_mac  <= q_sel;
         rd_size <= len_w;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dma_read_fifo.sv ====
// ======================================================================
// Small register FIFO that decouples buffer reads from bus writes
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "dma_params.svh"

module dma_read_fifo (
   input  wire     clk,
   input  wire     arst_n,
   dma_fifo_if.fifo fifo
);
   import dma_pkg::*;

   localparam int DEPTH = `DMA_FIFO_DEPTH;
   localparam int PW    = $clog2(DEPTH);

   word_t         mem [DEPTH];
   logic [PW-1:0] wr_ptr;   // Wraps at DEPTH
   logic [PW-1:0] rd_ptr;
   logic [PW:0]   count;    // Words held

   assign fifo.pop_data    = mem[rd_ptr];
   assign fifo.empty       = (count == '0);
   assign fifo.nearly_full = (count >= (PW+1)'(DEPTH - 1));

   always_ff @(posedge clk)
   begin
      if (fifo.push)
         mem[wr_ptr] <= fifo.push_data;
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (fifo.push)
            wr_ptr <= wr_ptr + 1'b1;
         if (fifo.pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({fifo.push, fifo.pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;  // Both or neither
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/dma_wb_master.sv ====
// ======================================================================
// Wishbone classic write master that drains the read FIFO to host memory
// One word per bus cycle, address and byte order set per packet
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "dma_params.svh"

module dma_wb_master (
   input  wire             clk,
   input  wire             arst_n,
   input  dma_pkg::word_t  rd_addr,     // Start byte address, word aligned
   input  wire             host_is_le,  // Low reverses bytes and selects
   dma_fifo_if.reader      fifo,
   dma_xfer_if.master      xfer,
   output logic            wb_cyc,
   output logic            wb_stb,
   output logic            wb_we,
   output dma_pkg::word_t  wb_adr,
   output dma_pkg::word_t  wb_dat_o,
   output dma_pkg::sel_t   wb_sel,
   input  wire             wb_ack
);
   import dma_pkg::*;

   localparam int LANES = `DMA_DATA_W / 8;

   logic  active;      // Packet words still to write
   logic  cyc;         // Bus cycle open
   logic  done_r;
   wcnt_t cnt;         // Words left minus one
   word_t adr;         // Address of the next word
   sel_t  last_sel_r;
   word_t dat;
   sel_t  sel;
   word_t dat_sw;
   sel_t  sel_cur;
   sel_t  sel_sw;
   logic  open_cyc;

   assign sel_cur  = (cnt == '0) ? last_sel_r : '1;  // Partial on last word only
   assign open_cyc = active && !fifo.empty && !cyc;
   assign fifo.pop = cyc && wb_ack;

   // ==================================================================
   // Endian swap of data and selects
   // ==================================================================
   always_comb
   begin
      for (int b = 0; b < LANES; b++)
      begin
         if (host_is_le)
         begin
            dat_sw[8*b +: 8] = fifo.pop_data[8*b +: 8];
            sel_sw[b]        = sel_cur[b];
         end
         else
         begin
            dat_sw[8*b +: 8] = fifo.pop_data[8*(LANES-1-b) +: 8];
            sel_sw[b]        = sel_cur[LANES-1-b];
         end
      end
   end

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         active <= 1'b0;
         cyc    <= 1'b0;
         done_r <= 1'b0;
         cnt    <= '0;
         adr    <= '0;
      end
      else
      begin
         done_r <= 1'b0;
         if (xfer.start)
         begin
            active <= 1'b1;
            cnt    <= xfer.words;
            adr    <= rd_addr;
         end
         else if (fifo.pop)
         begin
            cyc <= 1'b0;         // Idle at least one cycle
            adr <= adr + 'd4;
            if (cnt == '0)
            begin
               active <= 1'b0;
               done_r <= 1'b1;
            end
            else
               cnt <= cnt - 1'b1;
         end
         else if (open_cyc)
            cyc <= 1'b1;
      end
   end

   // Data and selects held through the cycle
   always_ff @(posedge clk)
   begin
      if (open_cyc)
      begin
         dat <= dat_sw;
         sel <= sel_sw;
      end
      if (xfer.start)
         last_sel_r <= xfer.last_sel;
   end

   assign wb_cyc    = cyc;
   assign wb_stb    = cyc;
   assign wb_we     = cyc;  // Write-only master
   assign wb_adr    = adr;
   assign wb_dat_o  = dat;
   assign wb_sel    = sel;
   assign xfer.done = done_r;

endmodule

`default_nettype wire

// ==== rtl/dma_engine.sv ====
// ======================================================================
// Packet DMA receive engine top: buffer queues to host memory over Wishbone
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "dma_params.svh"

module dma_engine (
   input  wire                   clk,
   input  wire                   arst_n,
   // Host registers
   input  wire                   rd_owner,
   input  dma_pkg::word_t        rd_addr,
   input  wire                   host_is_le,
   output dma_pkg::queue_t       rd_mac,
   output dma_pkg::len_t         rd_size,
   output logic                  rd_done,
   output logic                  addr_err,
   // Packet buffer
   input  wire [`DMA_NUM_Q-1:0]  pkt_avail,
   output logic                  buf_req,
   output dma_pkg::queue_t       buf_req_q,
   output logic                  buf_rd_en,
   input  dma_pkg::word_t        buf_data,
   // Wishbone
   output logic                  wb_cyc,
   output logic                  wb_stb,
   output logic                  wb_we,
   output dma_pkg::word_t        wb_adr,
   output dma_pkg::word_t        wb_dat_o,
   output dma_pkg::sel_t         wb_sel,
   input  wire                   wb_ack
);

   logic            grant_vld;
   dma_pkg::queue_t grant_q;
   logic            take;

   dma_fifo_if fifo_bus ();
   dma_xfer_if xfer_bus ();

   // ==================================================================
   // Queue selection and control
   // ==================================================================
   dma_rr_arb rr_arb_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .pkt_avail (pkt_avail),
      .take      (take),
      .grant_vld (grant_vld),
      .grant_q   (grant_q)
   );

   dma_ctrl ctrl_i (
      .clk       (clk),
      .arst_n    (arst_n),
      .rd_owner  (rd_owner),
      .rd_addr   (rd_addr),
      .grant_vld (grant_vld),
      .grant_q   (grant_q),
      .take      (take),
      .buf_req   (buf_req),
      .buf_req_q (buf_req_q),
      .buf_rd_en (buf_rd_en),
      .buf_data  (buf_data),
      .rd_mac    (rd_mac),
      .rd_size   (rd_size),
      .rd_done   (rd_done),
      .addr_err  (addr_err),
      .fifo      (fifo_bus),
      .xfer      (xfer_bus)
   );

   // ==================================================================
   // Data path to host memory
   // ==================================================================
   dma_read_fifo read_fifo_i (
      .clk    (clk),
      .arst_n (arst_n),
      .fifo   (fifo_bus)
   );

   dma_wb_master wb_master_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .rd_addr    (rd_addr),
      .host_is_le (host_is_le),
      .fifo       (fifo_bus),
      .xfer       (xfer_bus),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_o   (wb_dat_o),
      .wb_sel     (wb_sel),
      .wb_ack     (wb_ack)
   );

endmodule

`default_nettype wire

// ==== bench/dma_engine_tb.sv ====
// ======================================================================
// Testbench for the DMA receive engine with buffer and memory models
// Random packets, round-robin, address, select and completion checks
// ======================================================================
`timescale 1ns/10ps
`default_nettype none

`include "dma_params.svh"

module dma_engine_tb;
   import dma_pkg::*;

   localparam int NUM_PKT = 20;
   localparam int TIMEOUT = 3000;   // Rounded up from 20 x (17 x 6 + 20) + 200

   logic                  clk;
   logic                  arst_n;
   logic                  rd_owner;
   word_t                 rd_addr;
   logic                  host_is_le;
   queue_t                rd_mac;
   len_t                  rd_size;
   logic                  rd_done;
   logic                  addr_err;
   logic [`DMA_NUM_Q-1:0] pkt_avail;
   logic                  buf_req;
   queue_t                buf_req_q;
   logic                  buf_rd_en;
   word_t                 buf_data;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   word_t                 wb_adr;
   word_t                 wb_dat_o;
   sel_t                  wb_sel;
   logic                  wb_ack;

   // Model state
   word_t seed = 32'h60f3_67fb;
   int    len_tab [`DMA_NUM_Q][NUM_PKT];  // Packet lengths per queue
   int    q_cnt [`DMA_NUM_Q];
   int    q_head [`DMA_NUM_Q];            // Next packet per queue
   word_t exp_data [16];                  // Words handed out for this packet
   int    last_q;                         // Last granted queue
   int    cur_q;
   int    cur_len;
   int    rd_idx;                         // Buffer reads since buf_req
   int    wr_cnt;                         // Acked bus writes
   int    ack_wait;
   int    cycles;
   logic  in_cyc;                         // Bus cycle already checked
   logic  no_xfer;                        // Unaligned trial running
   logic  done_seen;
   logic  err_seen;
   word_t base_addr;
   string test_name;

   dma_engine dma_engine_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   always @(posedge clk)
   begin
      cycles++;
      if (cycles > TIMEOUT)
      begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
         end_with_failure();
      end
   end

   // ==================================================================
   // Helpers
   // ==================================================================
   task automatic end_with_failure();
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic expect_eq(input string what, input word_t exp, input word_t act);
      assert (exp == act)
      else
      begin
         $display("Error in %s, %s: expected %0h, actual %0h", test_name, what, exp, act);
         end_with_failure();
      end
   endtask

   task automatic expect_true(input logic cond, input string msg);
      assert (cond)
      else
      begin
         $display("In %s: %s", test_name, msg);
         end_with_failure();
      end
   endtask

   function automatic word_t next_rand();
      seed = seed * 32'd1664525 + 32'd1013904223;  // LCG step
      return seed;
   endfunction

   function automatic logic [`DMA_NUM_Q-1:0] avail_bits();
      logic [`DMA_NUM_Q-1:0] a;
      for (int q = 0; q < `DMA_NUM_Q; q++)
         a[q] = (q_head[q] < q_cnt[q]);
      return a;
   endfunction

   // First set queue above the last grant, wrapping
   function automatic int rr_pick(input logic [`DMA_NUM_Q-1:0] avail, input int last);
      int q;
      for (int i = 1; i <= `DMA_NUM_Q; i++)
      begin
         q = (last + i) % `DMA_NUM_Q;
         if (avail[q])
            return q;
      end
      return -1;
   endfunction

   function automatic int words_of(input int len);
      return (len + 3) / 4;
   endfunction

   function automatic sel_t exp_sel(input int k, input int len);
      int rem;
      rem = len % 4;
      if (k == words_of(len) - 1 && rem != 0)
         return sel_t'((1 << rem) - 1);   // Low lanes of a short last word
      return 4'hf;
   endfunction

   function automatic word_t swap_bytes(input word_t d);
      word_t r;
      for (int b = 0; b < 4; b++)
         r[8*b +: 8] = d[8*(3-b) +: 8];
      return r;
   endfunction

   function automatic sel_t swap_sel(input sel_t s);
      sel_t r;
      for (int b = 0; b < 4; b++)
         r[b] = s[3-b];
      return r;
   endfunction

   // ==================================================================
   // One clock sampled at the falling edge and driven after the rising
   // ==================================================================
   task automatic next_cycle();
      word_t buf_nxt;
      logic  ack_nxt;
      word_t tmp;
      word_t exp_w;
      sel_t  exp_s;
      int    exp_q;
      @(negedge clk);
      buf_nxt = 32'hdead_0000 | word_t'(cycles);  // Junk when no read
      ack_nxt = 1'b0;
      if (no_xfer)
         expect_true(!buf_req && !wb_cyc, "buffer request or bus cycle after address error");
      else
         expect_true(!addr_err, "addr_err pulsed for an aligned address");
      if (addr_err)
         err_seen = 1'b1;
      if (rd_done)
      begin
         expect_eq("rd_mac", word_t'(cur_q), word_t'(rd_mac));
         expect_eq("rd_size", word_t'(cur_len), word_t'(rd_size));
         expect_eq("write count", word_t'(words_of(cur_len)), word_t'(wr_cnt));
         done_seen = 1'b1;
      end
      // Buffer model
      if (buf_req)
      begin
         exp_q = rr_pick(avail_bits(), last_q);
         expect_eq("buf_req_q", word_t'(exp_q), word_t'(buf_req_q));
         last_q  = exp_q;
         cur_q   = exp_q;
         cur_len = len_tab[cur_q][q_head[cur_q]];
         q_head[cur_q]++;
         rd_idx  = 0;
         wr_cnt  = 0;
      end
      if (buf_rd_en)
      begin
         tmp = next_rand();
         if (rd_idx == 0)
            buf_nxt = {tmp[31:16], len_t'(cur_len)};  // Length word
         else
         begin
            expect_true(rd_idx <= words_of(cur_len), "buffer read past end of packet");
            exp_data[rd_idx-1] = tmp;
            buf_nxt = tmp;
         end
         rd_idx++;
      end
      // Memory slave
      if (wb_cyc && !wb_ack)
      begin
         if (!in_cyc)
         begin
            in_cyc   = 1'b1;
            tmp      = next_rand();
            ack_wait = int'(tmp[9:8]);   // 0 to 3 wait cycles
            expect_true(wr_cnt < words_of(cur_len), "bus write beyond end of packet");
            expect_eq("wb_we wb_stb", 32'h3, {30'b0, wb_we, wb_stb});
            expect_eq("wb_adr", base_addr + word_t'(4 * wr_cnt), wb_adr);
            exp_w = host_is_le ? exp_data[wr_cnt] : swap_bytes(exp_data[wr_cnt]);
            expect_eq("wb_dat_o", exp_w, wb_dat_o);
            exp_s = exp_sel(wr_cnt, cur_len);
            if (!host_is_le)
               exp_s = swap_sel(exp_s);
            expect_eq("wb_sel", word_t'(exp_s), word_t'(wb_sel));
         end
         if (ack_wait == 0)
            ack_nxt = 1'b1;
         else
            ack_wait--;
      end
      if (wb_cyc && wb_ack)
      begin
         in_cyc = 1'b0;   // Write recorded
         wr_cnt++;
      end
      @(posedge clk);
      #1;
      buf_data  = buf_nxt;
      wb_ack    = ack_nxt;
      pkt_avail = avail_bits();
   endtask

   // ==================================================================
   // Trials
   // ==================================================================
   task automatic run_packet(input int t);
      word_t tmp;
      test_name  = $sformatf("packet %0d", t);
      tmp        = next_rand();
      rd_addr    = {tmp[31:2], 2'b00};
      base_addr  = rd_addr;
      host_is_le = next_rand() > 32'h8000_0000;
      done_seen  = 1'b0;
      rd_owner   = 1'b1;
      while (!done_seen)
         next_cycle();
      rd_owner = 1'b0;     // Hand the buffer back
      repeat (2) next_cycle();
   endtask

   task automatic run_unaligned(input int t);
      word_t tmp;
      test_name = $sformatf("unaligned address %0d", t);
      tmp       = next_rand();
      rd_addr   = (tmp[1:0] == 2'b00) ? (tmp | 32'h1) : tmp;
      no_xfer   = 1'b1;
      err_seen  = 1'b0;
      rd_owner  = 1'b1;
      while (!err_seen)
         next_cycle();
      repeat (4) next_cycle();  // Engine must stay quiet in RELEASE
      rd_owner = 1'b0;
      repeat (2) next_cycle();
      no_xfer = 1'b0;
   endtask

   initial
   begin
      word_t tmp;
      int    q;
      arst_n = 1'b0;
      rd_owner = 1'b0;
      rd_addr = '0;
      host_is_le = 1'b1;
      pkt_avail = '0;
      buf_data = '0;
      wb_ack = 1'b0;
      cycles = 0;
      last_q = `DMA_NUM_Q - 1;   // Search starts at queue 0
      cur_q = 0;
      cur_len = 0;
      rd_idx = 0;
      wr_cnt = 0;
      ack_wait = 0;
      in_cyc = 1'b0;
      no_xfer = 1'b0;
      done_seen = 1'b0;
      err_seen = 1'b0;
      base_addr = '0;
      test_name = "reset";
      for (int i = 0; i < `DMA_NUM_Q; i++)
      begin
         q_cnt[i]  = 0;
         q_head[i] = 0;
      end
      // Spread packets of 1 to 64 bytes over the queues
      for (int t = 0; t < NUM_PKT; t++)
      begin
         tmp = next_rand();
         q   = int'(tmp[5:4]);
         len_tab[q][q_cnt[q]] = int'(tmp[13:8]) + 1;
         q_cnt[q]++;
      end
      pkt_avail = avail_bits();
      repeat (2) @(posedge clk);
      #1;
      expect_eq("outputs in reset", 32'h0,
                {26'b0, wb_cyc, wb_stb, buf_req, buf_rd_en, rd_done, addr_err});
      arst_n = 1'b1;
      for (int t = 0; t < NUM_PKT; t++)
      begin
         if (t % 7 == 0)
            run_unaligned(t / 7);
         run_packet(t);
      end
      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+rtl
rtl/dma_pkg.sv
rtl/dma_fifo_if.sv
rtl/dma_xfer_if.sv
rtl/dma_rr_arb.sv
rtl/dma_ctrl.sv
rtl/dma_read_fifo.sv
rtl/dma_wb_master.sv
rtl/dma_engine.sv
bench/dma_engine_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build the DMA engine testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f verilog.f --top-module dma_engine_tb

out=$(./obj_dir/Vdma_engine_tb 2>&1) || true
echo "$out"
echo "$out" | grep -qF "all tests passed"
